//--- verilog.f
+incdir+.
usb_pid_pkg.sv
usb_host_pkg.sv
usb_tx_if.sv
usb_tx_sie.sv
usb_rx_check.sv
usb_ctrl.sv
usb_host_ctrl_top.sv
usb_host_ctrl_assert.sv
tb_usb_host_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_usb_host_ctrl -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tb_usb_host_ctrl.sv
`timescale 1ns/1ns
`include "usb_host_defs.svh"

module tb_usb_host_ctrl;
    import usb_pid_pkg::*;
    import usb_host_pkg::*;

    localparam int NUM_XFERS    = 40;
    localparam int MAX_NAKS     = 3;
    // SETUP token, DATA0, four IN tokens and the ACK.
    localparam int TX_BYTES_MAX = 3 + 3 + `USB_SETUP_BYTES + 4 * 3 + 1;
    localparam int XFER_BOUND   = TX_BYTES_MAX * 4 + 7 * 4 + 4 * `USB_NAK_WAIT
                                  + 6 * `USB_RX_TIMEOUT + 16;
    localparam int CYCLE_LIMIT  = 16 + NUM_XFERS * XFER_BOUND;

    logic              c;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    logic [ADDR_W-1:0] addr;
    logic [63:0]       setup_data;
    logic              resp_valid;
    logic              resp_ready;
    xfer_status_t      resp_status;
    logic [63:0]       resp_data;
    logic [3:0]        resp_len;
    logic [7:0]        tx_byte;
    logic              tx_valid;
    logic              tx_ready;
    logic [7:0]        rx_byte;
    logic              rx_valid;

    int          cycles = 0;
    int          errors;
    int          low_run;
    logic        xfer_busy;
    logic [31:0] rng_state;
    logic [7:0]  tx_q[$];
    int          tx_cyc_q[$];
    logic [7:0]  pkt_q[$];
    logic [7:0]  reply_q[$];

    usb_host_ctrl_top uut (
        .c(c), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .addr(addr), .setup_data(setup_data),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_status(resp_status),
        .resp_data(resp_data), .resp_len(resp_len),
        .tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    initial begin
        c = 1'b0;
        forever #2 c = ~c;
    end

    always @(posedge c) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("Simulation timed out after %0d cycles with %0d errors", cycles, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Last token byte. CRC5 covers the 7 address bits and the 4 endpoint bits.
    function automatic logic [7:0] token_crc_byte(input logic [ADDR_W-1:0] a);
        logic [4:0] crc;
        crc = crc5_step(5'h1F, {1'b0, a});
        crc = crc5_step(crc, 8'h00, 3);
        return {~crc, 3'b000};
    endfunction

    // Inverted CRC16 over the first n bytes of w, low byte first.
    function automatic logic [15:0] word_crc(input logic [63:0] w, input int n);
        logic [15:0] crc;
        crc = 16'hFFFF;
        for (int i = 0; i < n; i++) begin
            crc = crc16_step(crc, w[8*i +: 8]);
        end
        return ~crc;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expv,
                                   input logic [63:0] got);
        errors++;
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expv, got);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("[ERROR] t=%0t %s", $time, msg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Device side. One call per falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        logic [31:0] r;
        @(negedge c);
        r = rand32();
        if (xfer_busy && req_ready) begin
            report_problem("req_ready high while a transfer is in progress");
        end
        // Back-pressure runs last at most three cycles.
        if (low_run < 3 && r[1:0] == 2'b00) begin
            tx_ready = 1'b0;
            low_run++;
        end else begin
            tx_ready = 1'b1;
            low_run  = 0;
        end
        // tx_byte and tx_valid come from registers and hold until the rising edge.
        if (tx_valid && tx_ready) begin
            tx_q.push_back(tx_byte);
            tx_cyc_q.push_back(cycles);
        end
    endtask

    task automatic collect_packet(output int first_cyc);
        int need;
        pkt_q.delete();
        while (tx_q.size() == 0) begin
            next_cycle();
        end
        case (tx_q[0])
            PID_SETUP, PID_IN: need = 3;
            PID_DATA0:         need = 3 + `USB_SETUP_BYTES;
            default:           need = 1;
        endcase
        while (tx_q.size() < need) begin
            next_cycle();
        end
        first_cyc = tx_cyc_q[0];
        for (int i = 0; i < need; i++) begin
            pkt_q.push_back(tx_q.pop_front());
            void'(tx_cyc_q.pop_front());
        end
    endtask

    task automatic check_token(input logic [7:0] pid_exp, input logic [ADDR_W-1:0] a,
                               input string what);
        if (pkt_q.size() != 3) begin
            report_problem($sformatf("%s has %0d bytes instead of 3", what, pkt_q.size()));
        end else begin
            if (pkt_q[0] !== pid_exp) begin
                report_mismatch({what, " pid"}, pid_exp, pkt_q[0]);
            end
            if (pkt_q[1] !== {1'b0, a}) begin
                report_mismatch({what, " addr byte"}, {1'b0, a}, pkt_q[1]);
            end
            if (pkt_q[2] !== token_crc_byte(a)) begin
                report_mismatch({what, " crc5 byte"}, token_crc_byte(a), pkt_q[2]);
            end
        end
    endtask

    task automatic check_setup_data(input logic [63:0] setup);
        logic [15:0] crc;
        crc = word_crc(setup, `USB_SETUP_BYTES);
        if (pkt_q.size() != 3 + `USB_SETUP_BYTES) begin
            report_problem($sformatf("DATA0 packet has %0d bytes instead of 11", pkt_q.size()));
        end else begin
            if (pkt_q[0] !== PID_DATA0) begin
                report_mismatch("DATA0 pid", PID_DATA0, pkt_q[0]);
            end
            for (int i = 0; i < `USB_SETUP_BYTES; i++) begin
                if (pkt_q[1 + i] !== setup[8*i +: 8]) begin
                    report_mismatch($sformatf("DATA0 byte %0d", i), setup[8*i +: 8],
                                    pkt_q[1 + i]);
                end
            end
            if (pkt_q[9] !== crc[7:0] || pkt_q[10] !== crc[15:8]) begin
                report_mismatch("DATA0 crc16", crc, {pkt_q[10], pkt_q[9]});
            end
        end
    endtask

    task automatic build_data_reply(input logic [7:0] pid, input logic [63:0] w, input int n,
                                    input logic corrupt);
        logic [15:0] crc;
        crc = word_crc(w, n);
        reply_q.delete();
        reply_q.push_back(pid);
        for (int i = 0; i < n; i++) begin
            reply_q.push_back(w[8*i +: 8]);
        end
        reply_q.push_back(crc[7:0] ^ {7'b0000000, corrupt});
        reply_q.push_back(crc[15:8]);
    endtask

    task automatic send_reply(output int last_cyc);
        int gap;
        if (tx_q.size() != 0) begin
            report_problem("extra tx bytes before the device reply");
        end
        gap = 2 + int'(rand32() % 9);
        repeat (gap) begin
            next_cycle();
        end
        foreach (reply_q[i]) begin
            next_cycle();
            rx_valid = 1'b1;
            rx_byte  = reply_q[i];
        end
        last_cyc = cycles;
        next_cycle();
        rx_valid = 1'b0;
        rx_byte  = 8'h00;
    endtask

    task automatic send_handshake(input logic [7:0] pid, output int last_cyc);
        reply_q.delete();
        reply_q.push_back(pid);
        send_reply(last_cyc);
    endtask

    task automatic wait_response(input xfer_status_t st_exp, input logic [3:0] len_exp,
                                 input logic [63:0] data_exp);
        int           hold;
        xfer_status_t st;
        logic [63:0]  d;
        logic [3:0]   n;
        while (!resp_valid) begin
            next_cycle();
        end
        st = resp_status;
        d  = resp_data;
        n  = resp_len;
        if (st !== st_exp) begin
            report_mismatch("resp_status", st_exp, st);
        end
        if (st_exp == STATUS_OK && n !== len_exp) begin
            report_mismatch("resp_len", len_exp, n);
        end
        if (st_exp == STATUS_OK && d !== data_exp) begin
            report_mismatch("resp_data", data_exp, d);
        end
        hold = int'(rand32() % 4);
        repeat (hold) begin
            next_cycle();
            if (!resp_valid) begin
                report_problem("resp_valid dropped while resp_ready was low");
            end
            if (resp_status !== st || resp_data !== d || resp_len !== n) begin
                report_problem("response fields changed while resp_ready was low");
            end
        end
        resp_ready = 1'b1;
        xfer_busy  = 1'b0;
        next_cycle();
        resp_ready = 1'b0;
        if (resp_valid) begin
            report_problem("resp_valid still high after the response was taken");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One control read with random NAKs, length and fault.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_transfer();
        logic [ADDR_W-1:0] a;
        logic [63:0]       setup;
        logic [63:0]       dev_data;
        int                naks;
        int                len;
        int                fault;
        int                t_first;
        int                t_nak;
        xfer_status_t      st_exp;
        a        = ADDR_W'(rand32());
        setup    = {rand32(), rand32()};
        naks     = int'(rand32() % (MAX_NAKS + 1));
        len      = int'(rand32() % 9);
        fault    = int'(rand32() % 8);
        dev_data = {rand32(), rand32()} & ~(64'hFFFF_FFFF_FFFF_FFFF << (8 * len));
        t_nak    = 0;

        if (!req_ready) begin
            report_problem("req_ready low while the controller is idle");
        end
        req_valid  = 1'b1;
        addr       = a;
        setup_data = setup;
        next_cycle();
        req_valid  = 1'b0;
        xfer_busy  = 1'b1;

        collect_packet(t_first);
        check_token(PID_SETUP, a, "SETUP token");
        collect_packet(t_first);
        check_setup_data(setup);
        send_handshake(PID_ACK, t_nak);

        for (int n = 0; n <= naks; n++) begin
            collect_packet(t_first);
            check_token(PID_IN, a, "IN token");
            if (n > 0 && t_first - t_nak < `USB_NAK_WAIT) begin
                report_problem("IN token retried too early after a NAK");
            end
            if (n < naks) begin
                send_handshake(PID_NAK, t_nak);
            end
        end

        // Faults 4 to 7 break the reply. Lower values give a good DATA1.
        st_exp = STATUS_OK;
        case (fault)
            4: begin
                reply_q.delete();
                reply_q.push_back(PID_STALL);
                st_exp = STATUS_STALL;
            end
            5: begin
                build_data_reply(PID_DATA1, dev_data, len, 1'b1);
                st_exp = STATUS_CRC_ERR;
            end
            6: begin
                build_data_reply(PID_DATA0, dev_data, len, 1'b0);
                st_exp = STATUS_PID_ERR;
            end
            7: begin
                reply_q.delete();
                st_exp = STATUS_TIMEOUT;
            end
            default: build_data_reply(PID_DATA1, dev_data, len, 1'b0);
        endcase
        if (fault != 7) begin
            send_reply(t_nak);
        end
        if (st_exp == STATUS_OK) begin
            collect_packet(t_first);
            if (pkt_q[0] !== PID_ACK) begin
                report_mismatch("ACK handshake", PID_ACK, pkt_q[0]);
            end
        end
        wait_response(st_exp, 4'(len), dev_data);
        if (tx_q.size() != 0) begin
            report_problem("tx packet sent after the transfer ended");
            tx_q.delete();
            tx_cyc_q.delete();
        end
    endtask

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        addr       = '0;
        setup_data = '0;
        resp_ready = 1'b0;
        tx_ready   = 1'b0;
        rx_byte    = 8'h00;
        rx_valid   = 1'b0;
        rng_state  = 32'd1;
        errors     = 0;
        low_run    = 0;
        xfer_busy  = 1'b0;
        repeat (8) begin
            @(negedge c);
        end
        rst = 1'b0;
        for (int i = 0; i < NUM_XFERS; i++) begin
            run_transfer();
        end
        $display("Finished %0d transfers with %0d errors", NUM_XFERS, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- usb_host_ctrl_assert.sv
`timescale 1ns/1ns

module usb_host_ctrl_assert (
    input logic                           c,
    input logic                           rst,
    input logic                           req_valid,
    input logic                           req_ready,
    input logic [usb_pid_pkg::ADDR_W-1:0] addr,
    input logic [63:0]                    setup_data,
    input logic                           resp_valid,
    input logic                           resp_ready,
    input usb_host_pkg::xfer_status_t     resp_status,
    input logic [63:0]                    resp_data,
    input logic [3:0]                     resp_len,
    input logic [7:0]                     tx_byte,
    input logic                           tx_valid,
    input logic                           tx_ready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake hold rules on the top level.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    tx_hold: assert property (@(posedge c) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte))
        else $error("tx_byte changed or tx_valid dropped before the PHY took the byte");

    resp_hold: assert property (@(posedge c) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_status)
            && $stable(resp_data) && $stable(resp_len))
        else $error("response changed before resp_ready");

    req_hold: assert property (@(posedge c) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(addr) && $stable(setup_data))
        else $error("request changed before req_ready");

    // Idle outputs right after reset.
    reset_idle: assert property (@(posedge c)
        rst |=> !tx_valid && !resp_valid && req_ready)
        else $error("outputs not idle after reset");

endmodule

bind usb_host_ctrl_top usb_host_ctrl_assert u_assert (
    .c(c), .rst(rst),
    .req_valid(req_valid), .req_ready(req_ready), .addr(addr), .setup_data(setup_data),
    .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_status(resp_status),
    .resp_data(resp_data), .resp_len(resp_len),
    .tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready)
);

//--- usb_host_ctrl_top.sv
`timescale 1ns/1ns

module usb_host_ctrl_top (
    input  logic                           c,
    input  logic                           rst,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic [usb_pid_pkg::ADDR_W-1:0] addr,
    input  logic [63:0]                    setup_data,
    output logic                           resp_valid,
    input  logic                           resp_ready,
    output usb_host_pkg::xfer_status_t     resp_status,
    output logic [63:0]                    resp_data,
    output logic [3:0]                     resp_len,
    output logic [7:0]                     tx_byte,
    output logic                           tx_valid,
    input  logic                           tx_ready,
    input  logic [7:0]                     rx_byte,
    input  logic                           rx_valid
);
    import usb_pid_pkg::*;

    logic        rx_pkt_end;
    pid_t        rx_pid;
    logic        rx_crc_ok;
    logic [3:0]  rx_len;
    logic [63:0] rx_data;

    usb_tx_if tx_bus ();

    usb_ctrl u_ctrl (
        .c(c), .rst(rst),
        .req_valid(req_valid), .addr(addr), .setup_data(setup_data), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_status(resp_status),
        .resp_data(resp_data), .resp_len(resp_len),
        .tx(tx_bus.ctrl),
        .rx_pkt_end(rx_pkt_end), .rx_pid(rx_pid), .rx_crc_ok(rx_crc_ok),
        .rx_len(rx_len), .rx_data(rx_data)
    );

    usb_tx_sie u_tx_sie (
        .c(c), .rst(rst), .pkt(tx_bus.sie),
        .tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    usb_rx_check u_rx_check (
        .c(c), .rst(rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .pkt_end(rx_pkt_end), .pid(rx_pid), .crc_ok(rx_crc_ok),
        .len(rx_len), .data(rx_data)
    );

endmodule

//--- usb_ctrl.sv
`timescale 1ns/1ns
`include "usb_host_defs.svh"

module usb_ctrl (
    input  logic                           c,
    input  logic                           rst,
    input  logic                           req_valid,
    input  logic [usb_pid_pkg::ADDR_W-1:0] addr,
    input  logic [63:0]                    setup_data,
    output logic                           req_ready,
    output logic                           resp_valid,
    input  logic                           resp_ready,
    output usb_host_pkg::xfer_status_t     resp_status,
    output logic [63:0]                    resp_data,
    output logic [3:0]                     resp_len,
    usb_tx_if.ctrl                         tx,
    input  logic                           rx_pkt_end,
    input  usb_pid_pkg::pid_t              rx_pid,
    input  logic                           rx_crc_ok,
    input  logic [3:0]                     rx_len,
    input  logic [63:0]                    rx_data
);
    import usb_pid_pkg::*;
    import usb_host_pkg::*;

    localparam int NAK_W   = $clog2(`USB_NAK_WAIT);
    localparam int REPLY_W = $clog2(`USB_RX_TIMEOUT);
    localparam int BYTE_W  = $clog2(`USB_SETUP_BYTES);

    ctrl_state_t        state;
    logic               issued;
    logic [NAK_W-1:0]   nak_cnt;
    logic [REPLY_W-1:0] reply_cnt;
    logic [BYTE_W-1:0]  byte_cnt;
    logic [ADDR_W-1:0]  addr_q;
    logic [63:0]        shift;
    logic               reply_wait;
    logic               reply_late;
    logic               data_good;

    assign req_ready  = state == CS_IDLE;
    assign resp_valid = state == CS_RESP;
    assign reply_wait = state == CS_SETUP_HS || state == CS_IN_WAIT;
    assign reply_late = reply_cnt == REPLY_W'(`USB_RX_TIMEOUT - 1);
    assign data_good  = state == CS_IN_WAIT && rx_pkt_end && rx_pid == PID_DATA1 && rx_crc_ok;

    assign tx.addr      = addr_q;
    assign tx.data_byte = shift[7:0];
    assign tx.data_last = byte_cnt == BYTE_W'(`USB_SETUP_BYTES - 1);

    // One packet request per sending state, dropped once the engine takes it.
    always_comb begin
        tx.pkt_valid = 1'b0;
        tx.pkt_kind  = TOKEN;
        tx.pid       = PID_SETUP;
        case (state)
            CS_SETUP_TOK: tx.pkt_valid = !issued;
            CS_SETUP_DATA: begin
                tx.pkt_valid = !issued;
                tx.pkt_kind  = DATA;
                tx.pid       = PID_DATA0;
            end
            CS_IN_TOK: begin
                tx.pkt_valid = !issued;
                tx.pid       = PID_IN;
            end
            CS_ACK_TX: begin
                tx.pkt_valid = !issued;
                tx.pkt_kind  = HANDSHAKE;
                tx.pid       = PID_ACK;
            end
            default: tx.pkt_valid = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transfer FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge c) begin
        if (rst) begin
            state       <= CS_IDLE;
            issued      <= 1'b0;
            nak_cnt     <= '0;
            reply_cnt   <= '0;
            byte_cnt    <= '0;
            resp_status <= STATUS_OK;
        end else begin
            if (tx.pkt_valid && tx.pkt_ready) begin
                issued <= 1'b1;
            end else if (tx.pkt_done) begin
                issued <= 1'b0;
            end
            reply_cnt <= reply_wait ? reply_cnt + 1'b1 : '0;
            // Wraps back to zero on the last SETUP byte.
            if (tx.data_ready) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            case (state)
                CS_IDLE: if (req_valid) state <= CS_SETUP_TOK;
                CS_SETUP_TOK: if (tx.pkt_done) state <= CS_SETUP_DATA;
                CS_SETUP_DATA: if (tx.pkt_done) state <= CS_SETUP_HS;
                CS_SETUP_HS: begin
                    if (rx_pkt_end) begin
                        if (rx_pid == PID_ACK) begin
                            state <= CS_IN_TOK;
                        end else begin
                            state       <= CS_RESP;
                            resp_status <= rx_pid == PID_STALL ? STATUS_STALL : STATUS_PID_ERR;
                        end
                    end else if (reply_late) begin
                        state       <= CS_RESP;
                        resp_status <= STATUS_TIMEOUT;
                    end
                end
                CS_IN_TOK: if (tx.pkt_done) state <= CS_IN_WAIT;
                CS_IN_WAIT: begin
                    if (rx_pkt_end) begin
                        state <= CS_RESP;
                        case (rx_pid)
                            PID_DATA1: begin
                                if (rx_crc_ok) begin
                                    state <= CS_ACK_TX;
                                end else begin
                                    resp_status <= STATUS_CRC_ERR;
                                end
                            end
                            PID_NAK:   state <= CS_NAK_WAIT;
                            PID_STALL: resp_status <= STATUS_STALL;
                            default:   resp_status <= STATUS_PID_ERR;
                        endcase
                    end else if (reply_late) begin
                        state       <= CS_RESP;
                        resp_status <= STATUS_TIMEOUT;
                    end
                end
                CS_NAK_WAIT: begin
                    nak_cnt <= nak_cnt + 1'b1;
                    if (nak_cnt == NAK_W'(`USB_NAK_WAIT - 1)) begin
                        nak_cnt <= '0;
                        state   <= CS_IN_TOK;
                    end
                end
                CS_ACK_TX: begin
                    if (tx.pkt_done) begin
                        state       <= CS_RESP;
                        resp_status <= STATUS_OK;
                    end
                end
                CS_RESP: if (resp_ready) state <= CS_IDLE;
                default: state <= CS_IDLE;
            endcase
        end
    end

    // Request and reply payload.
    always_ff @(posedge c) begin
        if (state == CS_IDLE && req_valid) begin
            addr_q    <= addr;
            shift     <= setup_data;
            resp_data <= '0;
            resp_len  <= 4'd0;
        end else begin
            if (tx.data_ready) begin
                shift <= {8'h00, shift[63:8]};
            end
            if (data_good) begin
                resp_data <= rx_data;
                resp_len  <= rx_len;
            end
        end
    end

endmodule

//--- usb_rx_check.sv
`timescale 1ns/1ns

module usb_rx_check (
    input  logic              c,
    input  logic              rst,
    input  logic [7:0]        rx_byte,
    input  logic              rx_valid,
    output logic              pkt_end,
    output usb_pid_pkg::pid_t pid,
    output logic              crc_ok,
    output logic [3:0]        len,
    output logic [63:0]       data
);
    import usb_pid_pkg::*;

    logic        in_pkt;
    logic [1:0]  nhold;
    logic [15:0] hold;
    logic [15:0] crc_q;
    logic        first;
    logic        spill;

    assign first = rx_valid & ~in_pkt;
    // Two bytes stay back so the CRC never lands in the data word.
    assign spill = rx_valid & in_pkt & (nhold == 2'd2);

    assign crc_ok = nhold == 2'd2 && crc_q == CRC16_RESIDUE;

    always_ff @(posedge c) begin
        if (rst) begin
            in_pkt  <= 1'b0;
            pkt_end <= 1'b0;
            nhold   <= 2'd0;
            len     <= 4'd0;
        end else begin
            in_pkt  <= rx_valid;
            pkt_end <= in_pkt & ~rx_valid;
            if (first) begin
                nhold <= 2'd0;
                len   <= 4'd0;
            end else if (rx_valid && nhold != 2'd2) begin
                nhold <= nhold + 2'd1;
            end else if (spill && len != 4'hF) begin
                len <= len + 4'd1;
            end
        end
    end

    always_ff @(posedge c) begin
        if (first) begin
            pid   <= pid_t'(rx_byte);
            crc_q <= CRC16_INIT;
            data  <= '0;
        end else if (rx_valid) begin
            crc_q <= crc16_step(crc_q, rx_byte);
            hold  <= {rx_byte, hold[15:8]};
            if (spill && !len[3]) begin
                data[{len[2:0], 3'b000} +: 8] <= hold[7:0];
            end
        end
    end

endmodule

//--- usb_tx_sie.sv
`timescale 1ns/1ns

module usb_tx_sie (
    input  logic       c,
    input  logic       rst,
    usb_tx_if.sie      pkt,
    output logic [7:0] tx_byte,
    output logic       tx_valid,
    input  logic       tx_ready
);
    import usb_pid_pkg::*;
    import usb_host_pkg::*;

    localparam logic [ENDP_W-1:0] ENDP0 = '0;

    logic              busy;
    usb_tx_kind_t      kind_q;
    pid_t              pid_q;
    logic [ADDR_W-1:0] addr_q;
    logic [3:0]        cnt;
    logic [1:0]        tail;
    logic [CRC5_W-1:0] crc5_q;
    logic [CRC5_W-1:0] crc5_fin;
    logic [15:0]       crc16_q;
    logic              fire;
    logic              last;
    logic              in_payload;

    assign pkt.pkt_ready  = ~busy;
    assign tx_valid       = busy;
    assign fire           = busy & tx_ready;
    assign in_payload     = kind_q == DATA && cnt != 4'd0 && tail == 2'd0;
    assign pkt.data_ready = fire & in_payload;
    // The endpoint bits left over after the address byte close the CRC5.
    assign crc5_fin = crc5_step(crc5_q, {5'b00000, ENDP0[ENDP_W-1:1]}, ENDP_W - 1);

    always_comb begin
        case (kind_q)
            TOKEN:     last = cnt == 4'd2;
            HANDSHAKE: last = 1'b1;
            default:   last = tail == 2'd2;
        endcase
    end

    // Wire byte mux.
    always_comb begin
        tx_byte = pid_q;
        if (cnt != 4'd0) begin
            if (kind_q == TOKEN) begin
                if (cnt == 4'd1) begin
                    tx_byte = {ENDP0[0], addr_q};
                end else begin
                    tx_byte = {~crc5_fin, ENDP0[ENDP_W-1:1]};
                end
            end else if (kind_q == DATA) begin
                case (tail)
                    2'd0:    tx_byte = pkt.data_byte;
                    2'd1:    tx_byte = ~crc16_q[7:0];
                    default: tx_byte = ~crc16_q[15:8];
                endcase
            end
        end
    end

    always_ff @(posedge c) begin
        if (rst) begin
            busy         <= 1'b0;
            cnt          <= 4'd0;
            tail         <= 2'd0;
            pkt.pkt_done <= 1'b0;
        end else begin
            pkt.pkt_done <= fire & last;
            if (pkt.pkt_valid && !busy) begin
                busy <= 1'b1;
                cnt  <= 4'd0;
                tail <= 2'd0;
            end else if (fire) begin
                cnt <= cnt + 4'd1;
                if (last) begin
                    busy <= 1'b0;
                end
                if (tail != 2'd0) begin
                    tail <= tail + 2'd1;
                end else if (in_payload && pkt.data_last) begin
                    tail <= 2'd1;
                end
            end
        end
    end

    always_ff @(posedge c) begin
        if (pkt.pkt_valid && !busy) begin
            kind_q  <= pkt.pkt_kind;
            pid_q   <= pkt.pid;
            addr_q  <= pkt.addr;
            crc16_q <= CRC16_INIT;
        end else if (fire) begin
            if (in_payload) begin
                crc16_q <= crc16_step(crc16_q, pkt.data_byte);
            end
            if (kind_q == TOKEN && cnt == 4'd1) begin
                crc5_q <= crc5_step(CRC5_INIT, tx_byte);
            end
        end
    end

endmodule

//--- usb_tx_if.sv
`timescale 1ns/1ns

interface usb_tx_if;
    import usb_pid_pkg::*;
    import usb_host_pkg::*;

    logic              pkt_valid;
    logic              pkt_ready;
    usb_tx_kind_t      pkt_kind;
    pid_t              pid;
    logic [ADDR_W-1:0] addr;
    // Payload comes one byte per data_ready.
    logic [7:0]        data_byte;
    logic              data_last;
    logic              data_ready;
    logic              pkt_done;

    modport ctrl (
        output pkt_valid, pkt_kind, pid, addr, data_byte, data_last,
        input  pkt_ready, data_ready, pkt_done
    );

    modport sie (
        input  pkt_valid, pkt_kind, pid, addr, data_byte, data_last,
        output pkt_ready, data_ready, pkt_done
    );

endinterface

//--- usb_host_pkg.sv
package usb_host_pkg;

    typedef enum logic [3:0] {
        CS_IDLE,
        CS_SETUP_TOK,
        CS_SETUP_DATA,
        CS_SETUP_HS,
        CS_IN_TOK,
        CS_IN_WAIT,
        CS_NAK_WAIT,
        CS_ACK_TX,
        CS_RESP
    } ctrl_state_t;

    typedef enum logic [2:0] {
        STATUS_OK,
        STATUS_STALL,
        STATUS_CRC_ERR,
        STATUS_PID_ERR,
        STATUS_TIMEOUT
    } xfer_status_t;

    // Packet shape asked of the transmit engine.
    typedef enum logic [1:0] {
        TOKEN,
        DATA,
        HANDSHAKE
    } usb_tx_kind_t;

endpackage

//--- usb_pid_pkg.sv
package usb_pid_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PID bytes as they go on the wire, with the inverted check nibble on top.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [7:0] {
        PID_SETUP = 8'h2D,
        PID_IN    = 8'h69,
        PID_DATA0 = 8'hC3,
        PID_DATA1 = 8'h4B,
        PID_ACK   = 8'hD2,
        PID_NAK   = 8'h5A,
        PID_STALL = 8'h1E
    } pid_t;

    // Token field widths.
    localparam int ADDR_W = 7;
    localparam int ENDP_W = 4;
    localparam int CRC5_W = 5;

    localparam logic [CRC5_W-1:0] CRC5_INIT     = 5'h1F;
    localparam logic [15:0]       CRC16_INIT    = 16'hFFFF;
    // Register value after a good packet has run through, CRC bytes included.
    localparam logic [15:0]       CRC16_RESIDUE = 16'hB001;

    // Bits go LSB first, so both CRCs run in reflected form.
    function automatic logic [CRC5_W-1:0] crc5_step(input logic [CRC5_W-1:0] crc,
                                                   input logic [7:0] d,
                                                   input int nbits = 8);
        logic [CRC5_W-1:0] c5;
        logic              fb;
        c5 = crc;
        for (int i = 0; i < 8; i++) begin
            if (i < nbits) begin
                fb = c5[0] ^ d[i];
                c5 = c5 >> 1;
                if (fb) begin
                    c5 = c5 ^ 5'h14;
                end
            end
        end
        return c5;
    endfunction

    function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] d);
        logic [15:0] c16;
        logic        fb;
        c16 = crc;
        for (int i = 0; i < 8; i++) begin
            fb  = c16[0] ^ d[i];
            c16 = c16 >> 1;
            if (fb) begin
                c16 = c16 ^ 16'hA001;
            end
        end
        return c16;
    endfunction

endpackage

//--- usb_host_defs.svh
`ifndef USB_HOST_DEFS_SVH
`define USB_HOST_DEFS_SVH

// Idle cycles after a NAK before the IN token goes out again.
`define USB_NAK_WAIT 16

// Cycles allowed for the device to answer.
`define USB_RX_TIMEOUT 64

// SETUP payload size.
`define USB_SETUP_BYTES 8

`endif
